// ==== source/icache_pkg.sv ====
package icache_pkg;

    localparam int data_width     = 32;
    localparam int words_per_line = 4;
    localparam int line_bits      = data_width * words_per_line;
    localparam int assoc_num      = 2;    // way select and plru are two-way only
    localparam int index_width    = 8;    // 256 sets per way
    localparam int offset_width   = 4;    // byte offset in a line
    localparam int tag_width      = data_width - index_width - offset_width;

    typedef logic [data_width-1:0]        word_t;
    typedef logic [tag_width-1:0]         tag_t;
    typedef logic [index_width-1:0]       index_t;
    typedef logic [offset_width-1:0]      offset_t;
    typedef logic [line_bits-1:0]         line_t;    // word 0 in the low bits
    typedef logic [$clog2(assoc_num)-1:0] way_t;

    // fetch address as presented by the fetch stage
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } fetch_req_t;

    // line address on the refill port, offset always zero
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } refill_req_t;

    typedef enum logic [1:0] {
        lookup,
        miss,
        refill,
        refill_done
    } icache_state_t;

endpackage

// ==== source/tag_valid_ram.sv ====
`timescale 1ns/1ps

module tag_valid_ram #(
    parameter int SIZE = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               we,
    input  icache_pkg::index_t addr,
    input  icache_pkg::tag_t   wdata_tag,
    input  logic               wdata_valid,
    output icache_pkg::tag_t   rdata_tag,
    output logic               rdata_valid
);
    import icache_pkg::*;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } entry_t;

    entry_t mem [SIZE];
    logic   clearing;
    index_t clear_addr;

    // walk every set once after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            clearing   <= 1'b1;
            clear_addr <= '0;
        end else if (clearing) begin
            clear_addr <= clear_addr + 1'b1;
            if (clear_addr == index_t'(SIZE - 1))
                clearing <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (clearing)
            mem[clear_addr] <= '0;
        else if (we)
            mem[addr] <= '{tag: wdata_tag, valid: wdata_valid};
    end

    // async read so the hit is known in the request cycle
    assign rdata_tag   = mem[addr].tag;
    assign rdata_valid = mem[addr].valid;

endmodule

// ==== source/line_data_ram.sv ====
`timescale 1ns/1ps

module line_data_ram #(
    parameter int SIZE = 256
) (
    input  logic                clk,
    input  logic                we,
    input  logic                re,
    input  icache_pkg::index_t  addr,
    input  icache_pkg::line_t   wdata,
    output icache_pkg::line_t   rdata
);
    import icache_pkg::*;

    line_t mem [SIZE];

    // whole line lands in one cycle on refill
    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
    end

    // registered read, holds between requests
    always_ff @(posedge clk) begin
        if (re)
            rdata <= mem[addr];
    end

endmodule

// ==== source/plru_table.sv ====
`timescale 1ns/1ps

module plru_table #(
    parameter int SIZE = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               update,
    input  icache_pkg::index_t update_index,
    input  icache_pkg::way_t   hit_way,
    input  icache_pkg::index_t victim_index,
    output icache_pkg::way_t   victim
);
    import icache_pkg::*;

    // one bit per set, names the way not used most recently
    way_t lru_bits [SIZE];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SIZE; i++)
                lru_bits[i] <= '0;
        end else if (update) begin
            lru_bits[update_index] <= ~hit_way;   // point away from the hit
        end
    end

    assign victim = lru_bits[victim_index];

endmodule

// ==== source/icache.sv ====
`timescale 1ns/1ps

module icache #(
    parameter int SETS = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  icache_pkg::fetch_req_t  fetch_req,
    input  logic                    invalidate,
    input  icache_pkg::index_t      invalidate_index,
    output logic                    busy,
    output icache_pkg::word_t       inst_rdata,
    output logic                    rd_req,
    output icache_pkg::refill_req_t rd_addr,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  icache_pkg::line_t       ret_data
);
    import icache_pkg::*;

    icache_state_t state;
    icache_state_t state_next;

    fetch_req_t req_q;
    logic       req_valid;
    logic       clearing;
    index_t     clear_count;

    logic [assoc_num-1:0] hit_vec;
    logic [assoc_num-1:0] hit_vec_r;
    logic                 hit_r;
    logic                 lookup_q;
    way_t                 hit_way;
    way_t                 victim;

    index_t               index_addr;
    tag_t                 cmp_tag;
    logic                 inv_we;
    logic                 refill_we;
    logic                 data_re;
    logic [assoc_num-1:0] tag_we;
    logic [assoc_num-1:0] data_we;
    tag_t                 tag_wdata;
    logic                 valid_wdata;

    tag_t                 way_tag  [assoc_num];
    logic [assoc_num-1:0] way_valid;
    line_t                way_line [assoc_num];
    logic [$clog2(words_per_line)-1:0] word_sel;

    // tracks the clearing pass inside the tag stores
    always_ff @(posedge clk) begin
        if (reset) begin
            clearing    <= 1'b1;
            clear_count <= '0;
        end else if (clearing) begin
            clear_count <= clear_count + 1'b1;
            if (clear_count == index_t'(SETS - 1))
                clearing <= 1'b0;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (inst_valid)
            req_q <= fetch_req;
    end

    assign data_re = inst_valid | (state == refill_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            hit_vec_r <= '0;
            hit_r     <= 1'b0;
            lookup_q  <= 1'b0;
        end else begin
            lookup_q <= data_re;
            if (inst_valid)
                req_valid <= 1'b1;
            if (data_re) begin   // new request or re-check after refill
                hit_vec_r <= hit_vec;
                hit_r     <= |hit_vec;
            end
        end
    end

    assign busy = clearing | (req_valid & ~hit_r);

    // fetch owns the index in lookup, the buffered request otherwise
    always_comb begin
        if (state != lookup)
            index_addr = req_q.index;
        else if (inst_valid)
            index_addr = fetch_req.index;
        else
            index_addr = invalidate_index;
    end

    assign cmp_tag     = inst_valid ? fetch_req.tag : req_q.tag;
    assign inv_we      = invalidate & ~busy & ~inst_valid;
    assign refill_we   = (state == refill) & ret_valid;
    assign tag_wdata   = refill_we ? req_q.tag : '0;
    assign valid_wdata = refill_we;

    for (genvar w = 0; w < assoc_num; w++) begin : g_way
        assign hit_vec[w] = way_valid[w] & (way_tag[w] == cmp_tag);
        assign data_we[w] = refill_we & (victim == way_t'(w));
        assign tag_we[w]  = inv_we | data_we[w];

        tag_valid_ram #(
            .SIZE(SETS)
        ) u_tag (
            .clk        (clk),
            .reset      (reset),
            .we         (tag_we[w]),
            .addr       (index_addr),
            .wdata_tag  (tag_wdata),
            .wdata_valid(valid_wdata),
            .rdata_tag  (way_tag[w]),
            .rdata_valid(way_valid[w])
        );

        line_data_ram #(
            .SIZE(SETS)
        ) u_data (
            .clk  (clk),
            .we   (data_we[w]),
            .re   (data_re),
            .addr (index_addr),
            .wdata(ret_data),
            .rdata(way_line[w])
        );
    end

    assign hit_way = hit_vec_r[0] ? way_t'(0) : way_t'(1);

    plru_table #(
        .SIZE(SETS)
    ) u_plru (
        .clk         (clk),
        .reset       (reset),
        .update      (lookup_q & hit_r),
        .update_index(req_q.index),
        .hit_way     (hit_way),
        .victim_index(req_q.index),
        .victim      (victim)
    );

    assign word_sel   = req_q.offset[offset_width-1:2];
    assign inst_rdata = way_line[hit_way][word_sel*data_width +: data_width];

    assign rd_req  = (state == miss);
    assign rd_addr = '{tag: req_q.tag, index: req_q.index, offset: '0};

    always_ff @(posedge clk) begin
        if (reset)
            state <= lookup;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        unique case (state)
            lookup: begin
                if (req_valid && !hit_r)
                    state_next = miss;
            end
            miss: begin
                if (rd_rdy)   // held here while the rom is busy
                    state_next = refill;
            end
            refill: begin
                if (ret_valid)
                    state_next = refill_done;
            end
            refill_done: state_next = lookup;
            default:     state_next = lookup;
        endcase
    end

endmodule

// ==== source/inst_rom.sv ====
`timescale 1ns/1ps

module inst_rom #(
    parameter int WORDS          = 32,
    parameter int REFILL_LATENCY = 6
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rd_req,
    input  icache_pkg::refill_req_t rd_addr,
    output logic                    rd_rdy,
    output logic                    ret_valid,
    output icache_pkg::line_t       ret_data
);
    import icache_pkg::*;

    localparam int ADDR_W = $clog2(WORDS);
    localparam int CNT_W  = $clog2(REFILL_LATENCY + 1);

    word_t            mem [WORDS];
    logic             pending;
    logic [CNT_W-1:0] count;
    refill_req_t      line_addr;
    logic [29:0]      base_word;

    initial begin
        $readmemh("imem.hex", mem);
    end

    assign rd_rdy    = ~pending;
    assign ret_valid = pending & (count == '0);
    assign base_word = line_addr[31:2];   // word address of the line

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            count   <= '0;
        end else if (rd_req && rd_rdy) begin
            pending <= 1'b1;
            count   <= CNT_W'(REFILL_LATENCY - 1);
        end else if (ret_valid) begin
            pending <= 1'b0;
        end else if (pending) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req && rd_rdy)
            line_addr <= rd_addr;
    end

    // four consecutive words, wrapping at the end of the rom
    always_comb begin
        logic [29:0] word_idx;
        for (int k = 0; k < words_per_line; k++) begin
            word_idx = (base_word + 30'(k)) % 30'(WORDS);
            ret_data[k*data_width +: data_width] = mem[word_idx[ADDR_W-1:0]];
        end
    end

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
    parameter int SETS           = 256,
    parameter int ROM_WORDS      = 32,
    parameter int REFILL_LATENCY = 6
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  icache_pkg::fetch_req_t fetch_req,
    input  logic                   invalidate,
    input  icache_pkg::index_t     invalidate_index,
    output logic                   busy,
    output icache_pkg::word_t      inst_rdata
);
    import icache_pkg::*;

    // refill port
    logic        rd_req;
    refill_req_t rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_data;

    icache #(
        .SETS(SETS)
    ) u_icache (
        .clk             (clk),
        .reset           (reset),
        .inst_valid      (inst_valid),
        .fetch_req       (fetch_req),
        .invalidate      (invalidate),
        .invalidate_index(invalidate_index),
        .busy            (busy),
        .inst_rdata      (inst_rdata),
        .rd_req          (rd_req),
        .rd_addr         (rd_addr),
        .rd_rdy          (rd_rdy),
        .ret_valid       (ret_valid),
        .ret_data        (ret_data)
    );

    inst_rom #(
        .WORDS         (ROM_WORDS),
        .REFILL_LATENCY(REFILL_LATENCY)
    ) u_rom (
        .clk      (clk),
        .reset    (reset),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_rdy   (rd_rdy),
        .ret_valid(ret_valid),
        .ret_data (ret_data)
    );

endmodule

// ==== tb/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int ROM_WORDS  = 32;
    localparam int WAIT_LIMIT = 400;   // cycles, longer than the 256-set clearing pass

    logic       clk;
    logic       reset;
    logic       inst_valid;
    fetch_req_t fetch_req;
    logic       invalidate;
    index_t     invalidate_index;
    logic       busy;
    word_t      inst_rdata;

    word_t       model_mem [ROM_WORDS];
    logic [31:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_bad;
    logic        saw_rd_req;
    logic        timed_out = 1'b0;

    icache_top #(
        .SETS          (256),
        .ROM_WORDS     (ROM_WORDS),
        .REFILL_LATENCY(6)
    ) UUT (
        .clk             (clk),
        .reset           (reset),
        .inst_valid      (inst_valid),
        .fetch_req       (fetch_req),
        .invalidate      (invalidate),
        .invalidate_index(invalidate_index),
        .busy            (busy),
        .inst_rdata      (inst_rdata)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (UUT.rd_req)
            saw_rd_req = 1'b1;   // refill request seen on the rom port
    end

    // ends the run once a wait has given up
    initial begin
        @(posedge timed_out);
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // rom word at (address / 4) mod rom size
    function automatic word_t expected_word(input fetch_req_t addr);
        return model_mem[(addr >> 2) % ROM_WORDS];
    endfunction

    task automatic timeout_hit(input string what);
        $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
        timed_out = 1'b1;
        @(negedge timed_out);   // never comes, the watcher finishes the run
    endtask

    task automatic wait_busy_low(input string what);
        int n;
        n = 0;
        while (busy !== 1'b0) begin
            if (n == WAIT_LIMIT)
                timeout_hit(what);
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic fetch(input fetch_req_t addr, output logic was_hit);
        word_t want;
        want = expected_word(addr);
        @(posedge clk);
        #2;
        inst_valid = 1'b1;
        fetch_req  = addr;
        @(posedge clk);
        #1;
        was_hit = (busy === 1'b0);   // busy decides hit or miss in the next cycle
        #1;
        inst_valid = 1'b0;
        wait_busy_low("busy to fall after a miss");
        assert (inst_rdata === want)
        else begin
            errors++;
            $display("[ERROR] %0t: addr %h read %h, expected %h", $time, addr, inst_rdata, want);
        end
    endtask

    task automatic invalidate_set(input index_t idx);
        @(posedge clk);
        #2;
        invalidate       = 1'b1;
        invalidate_index = idx;
        @(posedge clk);
        #2;
        invalidate = 1'b0;
    endtask

    task automatic check_hit(input logic was_hit, input logic want, input string what);
        assert (was_hit === want)
        else begin
            errors++;
            $display("[ERROR] %0t: %s, expected a %s", $time, what, want ? "hit" : "miss");
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-12s ok", name);
        end else begin
            tests_bad++;
            $display("test %-12s %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        fetch_req_t  a;
        fetch_req_t  b;
        fetch_req_t  c;
        logic        hit;
        logic [31:0] r;
        int          e0;

        clk              = 1'b0;
        reset            = 1'b1;
        inst_valid       = 1'b0;
        fetch_req        = '0;
        invalidate       = 1'b0;
        invalidate_index = '0;
        saw_rd_req       = 1'b0;
        lfsr             = 32'ha52;
        errors           = 0;
        tests_run        = 0;
        tests_bad        = 0;
        $readmemh("imem.hex", model_mem);

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        wait_busy_low("the tag clearing pass");

        e0 = errors;
        a  = '{tag: 20'h12345, index: 8'h10, offset: 4'h8};
        fetch(a, hit);
        check_hit(hit, 1'b0, "first fetch after reset");
        assert (saw_rd_req)
        else begin
            errors++;
            $display("[ERROR] %0t: no refill request on the cold miss", $time);
        end
        end_test("cold_miss", e0);

        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            a.offset = offset_t'(4 * k);
            fetch(a, hit);
            check_hit(hit, 1'b1, "fetch within a cached line");
        end
        end_test("hit", e0);

        // three tags sharing set 5
        e0 = errors;
        a  = '{tag: 20'h00001, index: 8'h05, offset: 4'h4};
        b  = '{tag: 20'h00002, index: 8'h05, offset: 4'hc};
        c  = '{tag: 20'h00003, index: 8'h05, offset: 4'h0};
        fetch(a, hit);
        fetch(b, hit);
        check_hit(hit, 1'b0, "first fetch of line b");
        fetch(a, hit);
        check_hit(hit, 1'b1, "line a next to line b");
        fetch(b, hit);
        check_hit(hit, 1'b1, "line b next to line a");
        end_test("two_way", e0);

        e0 = errors;
        fetch(a, hit);
        fetch(c, hit);
        check_hit(hit, 1'b0, "line c in a full set");
        fetch(a, hit);
        check_hit(hit, 1'b1, "line a after c replaced b");
        fetch(b, hit);
        check_hit(hit, 1'b0, "line b after eviction");
        end_test("plru", e0);

        e0 = errors;
        a = '{tag: 20'h12345, index: 8'h10, offset: 4'h4};
        invalidate_set(8'h10);
        fetch(a, hit);
        check_hit(hit, 1'b0, "fetch after invalidate");
        fetch(a, hit);
        check_hit(hit, 1'b1, "refetch after invalidate");
        end_test("invalidate", e0);

        // small tag and index ranges so hits and evictions both show up
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            take_bits(4, r);
            if (r[3:0] == 4'd0) begin
                take_bits(3, r);
                invalidate_set(index_t'(r));
            end else begin
                take_bits(2, r);
                c.tag = tag_t'(r);
                take_bits(3, r);
                c.index = index_t'(r);
                take_bits(4, r);
                c.offset = offset_t'(r);
                fetch(c, hit);
            end
        end
        end_test("random", e0);

        $display("%0d tests run, %0d with errors, %0d failed checks",
                 tests_run, tests_bad, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== imem.hex ====
// one 32-bit instruction word per line, word addresses 0 to 31
00100093
00200113
002081b3
40110233
0041f2b3
0051e333
003123b3
00721433
0083d4b3
00a00513
00b00593
00c58633
00d006b3
00e6a733
00f7b7b3
0107f833
fff00893
01189913
0108a993
00092a03
01492223
00498a93
ffca8b13
016b0bb3
017b9c33
018c5cb3
000c8d63
001d0d13
01ad8db3
01bd9e13
00000e93
0000006f

// ==== flist.f ====
source/icache_pkg.sv
source/tag_valid_ram.sv
source/line_data_ram.sv
source/plru_table.sv
source/icache.sv
source/inst_rom.sv
source/icache_top.sv
tb/tb_icache.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_icache -o sim_icache
./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    exit 1
fi
